// File: Makefile
VERILATOR ?= verilator
TOP       ?= hdmi_video_tx_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= *** TEST PASSED ***

BIN     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(FILELIST) $(wildcard hw/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

$(BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(BIN)
	$(BIN) | tee /dev/stderr | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
+incdir+tests
hw/video_pkg.sv
hw/tmds_pkg.sv
hw/tmds_feed_if.sv
hw/video_timing.sv
hw/tmds_channel_feed.sv
hw/tmds_encoder.sv
hw/hdmi_video_tx.sv
tests/clk_gen.sv
tests/hdmi_video_tx_tb.sv

// File: hw/hdmi_video_tx.sv
module hdmi_video_tx
    import video_pkg::*;
    import tmds_pkg::*;
(
    input  logic         clk_pixel,
    input  logic         sys_rst,
    input  colour_t      red,
    input  colour_t      green,
    input  colour_t      blue,
    output hcount_t      hcount,
    output vcount_t      vcount,
    output logic         new_frame,
    output frame_count_t frame_count,
    output tmds_symbol_t tmds_red,
    output tmds_symbol_t tmds_green,
    output tmds_symbol_t tmds_blue
);

    // undelayed sync/active from the raster
    video_ctrl_t video_ctrl;

    // encoder outputs by channel index
    tmds_symbol_t [tmds_channels-1:0] symbols;

    tmds_feed_if feed_bus ();

    // **************************************************************************
    // raster timing
    // **************************************************************************

    video_timing video_timing_i (
        .clk_pixel   (clk_pixel),
        .sys_rst     (sys_rst),
        .hcount      (hcount),
        .vcount      (vcount),
        .ctrl        (video_ctrl),
        .new_frame   (new_frame),
        .frame_count (frame_count)
    );

    // line up sync with the late colour, split into channels
    tmds_channel_feed tmds_channel_feed_i (
        .clk_pixel (clk_pixel),
        .sys_rst   (sys_rst),
        .ctrl      (video_ctrl),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .feed      (feed_bus)
    );

    // **************************************************************************
    // one encoder per channel
    // **************************************************************************

    for (genvar ch = 0; ch < tmds_channels; ch++) begin : g_encoder
        tmds_encoder #(
            .channel (ch)
        ) tmds_encoder_i (
            .clk_pixel (clk_pixel),
            .sys_rst   (sys_rst),
            .feed      (feed_bus),
            .symbol    (symbols[ch])
        );
    end

    assign tmds_blue  = symbols[ch_blue];
    assign tmds_green = symbols[ch_green];
    assign tmds_red   = symbols[ch_red];

endmodule

// File: hw/tmds_channel_feed.sv
module tmds_channel_feed
    import video_pkg::*;
    import tmds_pkg::*;
(
    input  logic        clk_pixel,
    input  logic        sys_rst,
    input  video_ctrl_t ctrl,
    input  colour_t     red,
    input  colour_t     green,
    input  colour_t     blue,
    tmds_feed_if.feed   feed
);

    // **************************************************************************
    // sync/active delay line
    // **************************************************************************

    // stage 0 is the youngest, top stage lines up with the pixel colour
    video_ctrl_t [video_pipe_stages-1:0] ctrl_pipe;
    video_ctrl_t                         ctrl_late;

    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            ctrl_pipe <= '0;
        end else begin
            ctrl_pipe <= {ctrl_pipe[video_pipe_stages-2:0], ctrl};
        end
    end

    assign ctrl_late = ctrl_pipe[video_pipe_stages-1];

    // **************************************************************************
    // channel slots
    // **************************************************************************

    // colour already arrives late, goes straight through
    assign feed.data[ch_blue]  = blue;
    assign feed.data[ch_green] = green;
    assign feed.data[ch_red]   = red;

    // sync rides on blue only, c1 = vsync
    assign feed.ctrl[ch_blue]  = {ctrl_late.vsync, ctrl_late.hsync};
    assign feed.ctrl[ch_green] = 2'b00;
    assign feed.ctrl[ch_red]   = 2'b00;

    // data period vs control period
    assign feed.de = ctrl_late.active;

endmodule

// File: hw/tmds_encoder.sv
module tmds_encoder
    import video_pkg::*;
    import tmds_pkg::*;
#(
    parameter int channel = ch_blue
) (
    input  logic         clk_pixel,
    input  logic         sys_rst,
    tmds_feed_if.enc     feed,
    output tmds_symbol_t symbol
);

    colour_t      din;
    logic [3:0]   din_ones;
    logic         use_xnor;
    logic [8:0]   q_m;
    disparity_t   ones_q;
    disparity_t   zeros_q;
    disparity_t   disparity;
    disparity_t   disparity_next;
    tmds_symbol_t data_symbol;
    tmds_symbol_t ctrl_symbol;

    // **************************************************************************
    // stage 1: transition minimisation
    // **************************************************************************

    always_comb begin
        din      = feed.data[channel];
        din_ones = 4'($countones(din));
        // xnor when the byte is ones-heavy, tie at four broken by bit 0
        use_xnor = (din_ones > 4'd4) || ((din_ones == 4'd4) && !din[0]);
        q_m[0]   = din[0];
        for (int i = 1; i < 8; i++) begin
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ din[i]) : (q_m[i-1] ^ din[i]);
        end
        // bit 8 flags xor (1) or xnor (0)
        q_m[8] = ~use_xnor;
    end

    // **************************************************************************
    // stage 2: dc balance against the running disparity
    // **************************************************************************

    always_comb begin
        ones_q  = disparity_t'($countones(q_m[7:0]));
        zeros_q = disparity_t'(8) - ones_q;
        if ((disparity == '0) || (ones_q == zeros_q)) begin
            // no bias either way, bit 9 just marks inversion
            data_symbol = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            if (q_m[8]) begin
                disparity_next = disparity + ones_q - zeros_q;
            end else begin
                disparity_next = disparity + zeros_q - ones_q;
            end
        end else if (((disparity > 0) && (ones_q > zeros_q)) ||
                     ((disparity < 0) && (zeros_q > ones_q))) begin
            // invert to pull the disparity back toward zero
            data_symbol    = {1'b1, q_m[8], ~q_m[7:0]};
            disparity_next = disparity + (q_m[8] ? disparity_t'(2) : disparity_t'(0))
                             + zeros_q - ones_q;
        end else begin
            data_symbol    = {1'b0, q_m[8], q_m[7:0]};
            disparity_next = disparity - (q_m[8] ? disparity_t'(0) : disparity_t'(2))
                             + ones_q - zeros_q;
        end
    end

    // control period symbol from {c1, c0}
    always_comb begin
        case (feed.ctrl[channel])
            2'b00:   ctrl_symbol = tmds_ctrl_00;
            2'b01:   ctrl_symbol = tmds_ctrl_01;
            2'b10:   ctrl_symbol = tmds_ctrl_10;
            default: ctrl_symbol = tmds_ctrl_11;
        endcase
    end

    // one registered cycle, blanking restarts the disparity
    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            symbol    <= '0;
            disparity <= '0;
        end else if (!feed.de) begin
            symbol    <= ctrl_symbol;
            disparity <= '0;
        end else begin
            symbol    <= data_symbol;
            disparity <= disparity_next;
        end
    end

endmodule

// File: hw/tmds_feed_if.sv
interface tmds_feed_if
    import video_pkg::*;
    import tmds_pkg::*;
();

    // colour byte per channel, indexed by ch_blue/ch_green/ch_red
    colour_t    [tmds_channels-1:0] data;

    // control code per channel, only blue carries sync
    tmds_ctrl_t [tmds_channels-1:0] ctrl;

    // video enable, shared by all channels
    logic de;

    // feeder side
    modport feed (
        output data,
        output ctrl,
        output de
    );

    // encoder side
    modport enc (
        input data,
        input ctrl,
        input de
    );

endinterface

// File: hw/tmds_pkg.sv
package tmds_pkg;

    // one 10-bit symbol per channel per pixel
    typedef logic [9:0] tmds_symbol_t;

    // {c1, c0}, for blue that is {vsync, hsync}
    typedef logic [1:0] tmds_ctrl_t;

    // control period symbols, DVI table
    localparam tmds_symbol_t tmds_ctrl_00 = 10'b1101010100;
    localparam tmds_symbol_t tmds_ctrl_01 = 10'b0010101011;
    localparam tmds_symbol_t tmds_ctrl_10 = 10'b0101010100;
    localparam tmds_symbol_t tmds_ctrl_11 = 10'b1010101011;

    // channel slots, same order as the HDMI data pairs
    localparam int tmds_channels = 3;
    localparam int ch_blue  = 0;
    localparam int ch_green = 1;
    localparam int ch_red   = 2;

    // running disparity, ones minus zeros so far
    typedef logic signed [4:0] disparity_t;

endpackage

// File: hw/video_pkg.sv
package video_pkg;

    // **************************************************************************
    // 720p60 raster timing
    // **************************************************************************

    // horizontal, in pixels
    localparam int h_active = 1280;
    localparam int h_front  = 110;
    localparam int h_sync   = 40;
    localparam int h_back   = 220;
    localparam int h_total  = h_active + h_front + h_sync + h_back;

    // vertical, in lines
    localparam int v_active = 720;
    localparam int v_front  = 5;
    localparam int v_sync   = 5;
    localparam int v_back   = 20;
    localparam int v_total  = v_active + v_front + v_sync + v_back;

    // frame counter runs 0..59
    localparam int frames_per_rollover = 60;

    // cycles from counts to colour at the top ports
    localparam int video_pipe_stages = 4;

    // **************************************************************************
    // types
    // **************************************************************************

    typedef logic [10:0] hcount_t;
    typedef logic [9:0]  vcount_t;
    typedef logic [5:0]  frame_count_t;
    typedef logic [7:0]  colour_t;

    // sync and draw levels, travel together down the delay line
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic active;
    } video_ctrl_t;

endpackage

// File: hw/video_timing.sv
module video_timing
    import video_pkg::*;
(
    input  logic         clk_pixel,
    input  logic         sys_rst,
    output hcount_t      hcount,
    output vcount_t      vcount,
    output video_ctrl_t  ctrl,
    output logic         new_frame,
    output frame_count_t frame_count
);

    logic line_end;
    logic frame_end;
    logic frame_start_next;

    // last pixel of a line / last line of the raster
    assign line_end  = (hcount == hcount_t'(h_total - 1));
    assign frame_end = (vcount == vcount_t'(v_total - 1));

    // next edge shows the first blanking pixel under the active area
    assign frame_start_next = (hcount == hcount_t'(h_active - 1)) &&
                              (vcount == vcount_t'(v_active));

    // **************************************************************************
    // raster counters
    // **************************************************************************

    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            hcount <= '0;
            vcount <= '0;
        end else if (line_end) begin
            hcount <= '0;
            // line step only on hcount wrap
            vcount <= frame_end ? '0 : vcount + vcount_t'(1);
        end else begin
            hcount <= hcount + hcount_t'(1);
        end
    end

    // **************************************************************************
    // new frame pulse and 0..59 frame number
    // **************************************************************************

    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            new_frame   <= 1'b0;
            frame_count <= '0;
        end else begin
            new_frame <= frame_start_next;
            // counter changes on the same edge the pulse goes high
            if (frame_start_next) begin
                if (frame_count == frame_count_t'(frames_per_rollover - 1)) begin
                    frame_count <= '0;
                end else begin
                    frame_count <= frame_count + frame_count_t'(1);
                end
            end
        end
    end

    // sync windows and draw area, decoded from the visible counts
    always_comb begin
        // positive polarity for 720p
        ctrl.hsync  = (hcount >= hcount_t'(h_active + h_front)) &&
                      (hcount <  hcount_t'(h_active + h_front + h_sync));
        ctrl.vsync  = (vcount >= vcount_t'(v_active + v_front)) &&
                      (vcount <  vcount_t'(v_active + v_front + v_sync));
        ctrl.active = (hcount < hcount_t'(h_active)) && (vcount < vcount_t'(v_active));
    end

endmodule

// File: tests/clk_gen.sv
module clk_gen #(
    parameter int period = 4
) (
    output logic clk
);

    // starts low, first rising edge half a period in
    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

endmodule

// File: tests/tmds_ref_model.svh
// **************************************************************************
// reference model of the video path
// **************************************************************************

// what the DUT should show in the current cycle
hcount_t      m_hcount;
vcount_t      m_vcount;
logic         m_new_frame;
frame_count_t m_frame_count;
tmds_symbol_t m_symbol [tmds_channels];
int           m_disp [tmds_channels];
logic         m_sym_data;

// sync/active bundles still on their way to the encoders
video_ctrl_t  m_ctrl_q [$];

// sync windows and draw area from the raster rules
function automatic video_ctrl_t raster_ctrl(input hcount_t h, input vcount_t v);
    video_ctrl_t c;
    c.hsync  = (int'(h) >= h_active + h_front) && (int'(h) < h_active + h_front + h_sync);
    c.vsync  = (int'(v) >= v_active + v_front) && (int'(v) < v_active + v_front + v_sync);
    c.active = (int'(h) < h_active) && (int'(v) < v_active);
    return c;
endfunction

// control period lookup, index is {c1, c0}
function automatic tmds_symbol_t ctrl_code_symbol(input tmds_ctrl_t code);
    tmds_symbol_t table_q [4] = '{tmds_ctrl_00, tmds_ctrl_01, tmds_ctrl_10, tmds_ctrl_11};
    return table_q[code];
endfunction

// DVI 1.0 data encoding, disparity counted as ones minus zeros
function automatic tmds_symbol_t dvi_encode(input colour_t d, input int disp_in,
                                            output int disp_out);
    logic [8:0]   qm;
    int           n1_d;
    int           n1_q;
    int           n0_q;
    tmds_symbol_t q;
    n1_d  = $countones(d);
    qm[0] = d[0];
    if ((n1_d > 4) || ((n1_d == 4) && (d[0] == 1'b0))) begin
        for (int i = 1; i < 8; i++) begin
            qm[i] = qm[i-1] ~^ d[i];
        end
        qm[8] = 1'b0;
    end else begin
        for (int i = 1; i < 8; i++) begin
            qm[i] = qm[i-1] ^ d[i];
        end
        qm[8] = 1'b1;
    end
    n1_q = $countones(qm[7:0]);
    n0_q = 8 - n1_q;
    if ((disp_in == 0) || (n1_q == n0_q)) begin
        q        = {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
        disp_out = qm[8] ? disp_in + n1_q - n0_q : disp_in + n0_q - n1_q;
    end else if (((disp_in > 0) && (n1_q > n0_q)) || ((disp_in < 0) && (n0_q > n1_q))) begin
        q        = {1'b1, qm[8], ~qm[7:0]};
        disp_out = disp_in + (qm[8] ? 2 : 0) + n0_q - n1_q;
    end else begin
        q        = {1'b0, qm[8], qm[7:0]};
        disp_out = disp_in - (qm[8] ? 0 : 2) + n1_q - n0_q;
    end
    return q;
endfunction

// state right after a reset edge
task automatic model_reset();
    m_hcount      = '0;
    m_vcount      = '0;
    m_new_frame   = 1'b0;
    m_frame_count = '0;
    m_sym_data    = 1'b0;
    foreach (m_symbol[ch]) begin
        m_symbol[ch] = '0;
        m_disp[ch]   = 0;
    end
    m_ctrl_q.delete();
    repeat (video_pipe_stages) begin
        m_ctrl_q.push_back('0);
    end
endtask

// advance one clock, given reset and colour of the current cycle
task automatic model_step(input logic rst, input colour_t [tmds_channels-1:0] pix);
    video_ctrl_t late;
    int          disp_out;
    if (rst) begin
        model_reset();
    end else begin
        // bundle from video_pipe_stages cycles back meets today's colour
        m_ctrl_q.push_back(raster_ctrl(m_hcount, m_vcount));
        late       = m_ctrl_q.pop_front();
        m_sym_data = late.active;
        for (int ch = 0; ch < tmds_channels; ch++) begin
            if (late.active) begin
                m_symbol[ch] = dvi_encode(pix[ch], m_disp[ch], disp_out);
                m_disp[ch]   = disp_out;
            end else begin
                // sync only on blue, blanking clears the disparity
                m_symbol[ch] = ctrl_code_symbol((ch == ch_blue) ?
                                                {late.vsync, late.hsync} : 2'b00);
                m_disp[ch]   = 0;
            end
        end
        // raster step
        if (int'(m_hcount) == h_total - 1) begin
            m_hcount = '0;
            m_vcount = (int'(m_vcount) == v_total - 1) ? '0 : m_vcount + vcount_t'(1);
        end else begin
            m_hcount = m_hcount + hcount_t'(1);
        end
        // pulse and frame number both show on the first blanking pixel
        m_new_frame = (int'(m_hcount) == h_active) && (int'(m_vcount) == v_active);
        if (m_new_frame) begin
            m_frame_count = (int'(m_frame_count) == frames_per_rollover - 1) ?
                            '0 : m_frame_count + frame_count_t'(1);
        end
    end
endtask

// File: tests/hdmi_video_tx_tb.sv
module hdmi_video_tx_tb
    import video_pkg::*;
    import tmds_pkg::*;
();

    localparam int reset_cycles   = 16;
    localparam int mid_reset_max  = 6;
    localparam int frame_cycles   = h_total * v_total;
    // two frames, the mid-run reset and a margin
    localparam int timeout_cycles = (22 * frame_cycles) / 10 + reset_cycles + mid_reset_max;
    // enough lines past the pulse to run through vsync
    localparam int tail_cycles    = 12 * h_total;

    logic         clk_pixel;
    logic         sys_rst;
    colour_t      red;
    colour_t      green;
    colour_t      blue;
    hcount_t      hcount;
    vcount_t      vcount;
    logic         new_frame;
    frame_count_t frame_count;
    tmds_symbol_t tmds_red;
    tmds_symbol_t tmds_green;
    tmds_symbol_t tmds_blue;

    // run bookkeeping
    int   cycle_count = 0;
    int   pulses_after_reset;
    logic mid_reset_done;

    `include "tmds_ref_model.svh"

    clk_gen #(
        .period (4)
    ) clk_gen_i (
        .clk (clk_pixel)
    );

    hdmi_video_tx hdmi_video_tx_i (
        .clk_pixel   (clk_pixel),
        .sys_rst     (sys_rst),
        .red         (red),
        .green       (green),
        .blue        (blue),
        .hcount      (hcount),
        .vcount      (vcount),
        .new_frame   (new_frame),
        .frame_count (frame_count),
        .tmds_red    (tmds_red),
        .tmds_green  (tmds_green),
        .tmds_blue   (tmds_blue)
    );

    // **************************************************************************
    // compare tasks
    // **************************************************************************

    task automatic stop_with_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_count(input hcount_t h_got, input vcount_t v_got,
                               input hcount_t h_exp, input vcount_t v_exp, input string what);
        if ((h_got !== h_exp) || (v_got !== v_exp)) begin
            $display("FAIL @%0t: %s expected h=%0d v=%0d, got h=%0d v=%0d",
                     $time, what, h_exp, v_exp, h_got, v_got);
            stop_with_failure();
        end
    endtask

    task automatic check_frame(input logic nf_got, input frame_count_t fc_got,
                               input logic nf_exp, input frame_count_t fc_exp, input string what);
        if ((nf_got !== nf_exp) || (fc_got !== fc_exp)) begin
            $display("FAIL @%0t: %s expected new_frame=%0b frame=%0d, got new_frame=%0b frame=%0d",
                     $time, what, nf_exp, fc_exp, nf_got, fc_got);
            stop_with_failure();
        end
    endtask

    task automatic check_symbol(input tmds_symbol_t got, input tmds_symbol_t exp,
                                input int ch, input string what);
        if (got !== exp) begin
            $display("FAIL @%0t: %s on channel %0d expected %b, got %b",
                     $time, what, ch, exp, got);
            stop_with_failure();
        end
    endtask

    // **************************************************************************
    // each pixel clock checks at the falling edge, then drives and steps the model
    // **************************************************************************

    task automatic run_cycle(input logic rst);
        colour_t [tmds_channels-1:0] pix;
        string                       kind;
        @(negedge clk_pixel);
        kind = m_sym_data ? "data symbol" : "control symbol";
        check_count(hcount, vcount, m_hcount, m_vcount, "raster counters");
        check_frame(new_frame, frame_count, m_new_frame, m_frame_count, "frame pulse");
        check_symbol(tmds_blue, m_symbol[ch_blue], ch_blue, kind);
        check_symbol(tmds_green, m_symbol[ch_green], ch_green, kind);
        check_symbol(tmds_red, m_symbol[ch_red], ch_red, kind);
        // pulses of the restarted raster
        if (m_new_frame && mid_reset_done) begin
            pulses_after_reset++;
        end
        // fresh colour every cycle
        pix[ch_blue]  = colour_t'($urandom);
        pix[ch_green] = colour_t'($urandom);
        pix[ch_red]   = colour_t'($urandom);
        sys_rst = rst;
        blue    = pix[ch_blue];
        green   = pix[ch_green];
        red     = pix[ch_red];
        model_step(rst, pix);
    endtask

    // cycle limit so a stuck run still ends
    always @(posedge clk_pixel) begin
        cycle_count++;
        if (cycle_count > timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            stop_with_failure();
        end
    end

    initial begin
        int reset_at;
        int mid_len;
        sys_rst            = 1'b1;
        red                = '0;
        green              = '0;
        blue               = '0;
        pulses_after_reset = 0;
        mid_reset_done     = 1'b0;
        void'($urandom(32'hee93));
        model_reset();
        // the first rising edge already sees reset
        repeat (reset_cycles - 1) begin
            run_cycle(1'b1);
        end
        // mid-frame reset lands in the active lines of frame two
        reset_at = frame_cycles + int'($urandom_range(2 * h_total, frame_cycles / 8));
        mid_len  = int'($urandom_range(3, mid_reset_max));
        repeat (reset_at) begin
            run_cycle(1'b0);
        end
        repeat (mid_len) begin
            run_cycle(1'b1);
        end
        mid_reset_done = 1'b1;
        // restarted raster up to its first pulse
        while (pulses_after_reset == 0) begin
            run_cycle(1'b0);
        end
        repeat (tail_cycles) begin
            run_cycle(1'b0);
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
